/* axil_wb_bridge.f */
+incdir+include
rtl/axil_wb_pkg.sv
rtl/axil_wr_to_wb.sv
rtl/axil_rd_to_wb.sv
rtl/wb_rw_arbiter.sv
rtl/axil_to_wb_bridge.sv
sim/wb_mem_model.sv
sim/tb_axil_to_wb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AXI-lite to Wishbone bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
mkdir -p build &&
verilator --binary --timing --top-module tb_axil_to_wb -f axil_wb_bridge.f \
	--Mdir build -o tb_axil_to_wb > build/build.log 2>&1 ||
	{ cat build/build.log; echo "Build failed"; exit 1; }
./build/tb_axil_to_wb > build/sim.log 2>&1
cat build/sim.log
grep -q "CHECKS FAILED" build/sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" build/sim.log || { echo "Simulation ended early"; exit 1; }
echo "Simulation passed"

/* sim/tb_axil_to_wb.sv */
/*
 * Directed testbench for the AXI-lite to Wishbone bridge.
 * Memory model is 256 words, so only word-address bits 7:0 select a word.
 * Wishbone address bit 20 (AXI byte address bit 22) is the error region.
 * The run stops at the first mismatch.
 */
`default_nettype none
`include "axil_wb_defs.svh"

module tb_axil_to_wb;
	import axil_wb_pkg::*;

	localparam int MEM_DEPTH    = 256;
	localparam int ERR_BIT      = 20;
	localparam int STALL_PERIOD = 3;
	// Roughly 60 transactions at under 30 cycles each with margin
	localparam int TIMEOUT_CYCLES = 3000;

	integer    seed = 6;
	int        cycle_count;
	bus_data_t ref_mem [0:MEM_DEPTH-1];

	logic      clk;
	logic      rst;
	// AXI-lite side
	logic      awvalid, awready, wvalid, wready, bvalid, bready;
	logic      arvalid, arready, rvalid, rready;
	axil_addr_t awaddr, araddr;
	bus_data_t wdata, rdata;
	bus_sel_t  wstrb;
	axi_resp_t bresp, rresp;
	// Wishbone side
	logic      wb_cyc, wb_stb, wb_we, wb_stall, wb_ack, wb_err;
	wb_addr_t  wb_addr;
	bus_data_t wb_wdata, wb_rdata;
	bus_sel_t  wb_sel;

	axil_to_wb_bridge UUT (
		.i_clk(clk), .i_rst(rst),
		.i_axi_awvalid(awvalid), .o_axi_awready(awready), .i_axi_awaddr(awaddr),
		.i_axi_wvalid(wvalid), .o_axi_wready(wready),
		.i_axi_wdata(wdata), .i_axi_wstrb(wstrb),
		.o_axi_bvalid(bvalid), .i_axi_bready(bready), .o_axi_bresp(bresp),
		.i_axi_arvalid(arvalid), .o_axi_arready(arready), .i_axi_araddr(araddr),
		.o_axi_rvalid(rvalid), .i_axi_rready(rready),
		.o_axi_rdata(rdata), .o_axi_rresp(rresp),
		.o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_we(wb_we), .o_wb_addr(wb_addr),
		.o_wb_data(wb_wdata), .o_wb_sel(wb_sel), .i_wb_stall(wb_stall),
		.i_wb_ack(wb_ack), .i_wb_data(wb_rdata), .i_wb_err(wb_err)
	);

	wb_mem_model #(.DEPTH(MEM_DEPTH), .ERR_BIT(ERR_BIT), .STALL_PERIOD(STALL_PERIOD)) u_mem (
		.i_clk(clk), .i_rst(rst),
		.i_cyc(wb_cyc), .i_stb(wb_stb), .i_we(wb_we), .i_addr(wb_addr),
		.i_data(wb_wdata), .i_sel(wb_sel),
		.o_stall(wb_stall), .o_ack(wb_ack), .o_err(wb_err), .o_data(wb_rdata)
	);

	always #20 clk = ~clk;

	// Hang guard
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the bridge gave no response within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

	////////////////////////////////////////
	// Checks and reference model
	////////////////////////////////////////

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Fail: %s expected 0x%h got 0x%h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	function automatic bus_data_t fill_word(input logic [7:0] idx);
		return {idx, ~idx, idx ^ 8'h3c, 8'hc3};
	endfunction

	// Strobed bytes come from the new word
	function automatic bus_data_t merge_bytes(input bus_data_t old_word,
			input bus_data_t new_word, input bus_sel_t strb);
		bus_data_t merged;
		merged = old_word;
		for (int b = 0; b < `BUS_DATA_W / 8; b++)
			if (strb[b])
				merged[8*b +: 8] = new_word[8*b +: 8];
		return merged;
	endfunction

	function automatic axil_addr_t byte_addr(input logic [7:0] idx, input logic err);
		axil_addr_t addr;
		addr = axil_addr_t'(idx) << `AXIL_LSB;
		addr[ERR_BIT + `AXIL_LSB] = err;
		return addr;
	endfunction

	////////////////////////////////////////
	// AXI-lite master tasks
	////////////////////////////////////////

	// W may lead AW by w_lead cycles and bready stays low for b_hold cycles
	task automatic axi_write(input axil_addr_t addr, input bus_data_t data,
			input bus_sel_t strb, input int w_lead, input int b_hold, output axi_resp_t resp);
		logic aw_done;
		logic w_done;
		int   waited;
		aw_done = 1'b0;
		w_done  = 1'b0;
		waited  = 0;
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= (w_lead == 0);
		wdata   <= data;
		wstrb   <= strb;
		wvalid  <= 1'b1;
		bready  <= 1'b0;
		while (!(aw_done && w_done))
		begin
			@(negedge clk);
			if (awvalid && awready)
				aw_done = 1'b1;
			if (wvalid && wready)
				w_done = 1'b1;
			waited++;
			@(posedge clk);
			if (aw_done)
				awvalid <= 1'b0;
			else if (waited >= w_lead)
				awvalid <= 1'b1;
			if (w_done)
				wvalid <= 1'b0;
		end
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		resp = bresp;
		// Response sits still under back-pressure
		repeat (b_hold)
		begin
			@(negedge clk);
			check_equal("bvalid", 32'd1, 32'(bvalid));
			check_equal("bresp", 32'(resp), 32'(bresp));
		end
		@(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
		// Exactly one response
		@(negedge clk);
		check_equal("bvalid", 32'd0, 32'(bvalid));
	endtask

	task automatic axi_read(input axil_addr_t addr, input int r_hold,
			output bus_data_t data, output axi_resp_t resp);
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= 1'b0;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		arvalid <= 1'b0;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		resp = rresp;
		repeat (r_hold)
		begin
			@(negedge clk);
			check_equal("rvalid", 32'd1, 32'(rvalid));
			check_equal("rdata", data, rdata);
			check_equal("rresp", 32'(resp), 32'(rresp));
		end
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
		@(negedge clk);
		check_equal("rvalid", 32'd0, 32'(rvalid));
	endtask

	task automatic write_and_check(input logic [7:0] idx, input bus_data_t data,
			input bus_sel_t strb, input int w_lead, input int b_hold);
		axi_resp_t resp;
		axi_write(byte_addr(idx, 1'b0), data, strb, w_lead, b_hold, resp);
		check_equal("bresp", 32'(`RESP_OKAY), 32'(resp));
		ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
	endtask

	task automatic read_and_check(input logic [7:0] idx, input int r_hold);
		bus_data_t data;
		axi_resp_t resp;
		axi_read(byte_addr(idx, 1'b0), r_hold, data, resp);
		check_equal("rresp", 32'(`RESP_OKAY), 32'(resp));
		check_equal("rdata", ref_mem[idx], data);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_write_read();
		write_and_check(8'h21, bus_data_t'($random(seed)), 4'hf, 0, 0);
		read_and_check(8'h21, 0);
	endtask

	task automatic test_partial_strobe();
		write_and_check(8'h40, bus_data_t'($random(seed)), 4'b0101, 0, 0);
		read_and_check(8'h40, 0);
		write_and_check(8'h40, bus_data_t'($random(seed)), 4'b1000, 0, 0);
		read_and_check(8'h40, 0);
	endtask

	// Word 0x21 aliases the error address and must survive
	task automatic test_error_region();
		bus_data_t data;
		axi_resp_t resp;
		axi_write(byte_addr(8'h21, 1'b1), bus_data_t'($random(seed)), 4'hf, 0, 0, resp);
		check_equal("bresp", 32'(`RESP_SLVERR), 32'(resp));
		axi_read(byte_addr(8'h21, 1'b1), 0, data, resp);
		check_equal("rresp", 32'(`RESP_SLVERR), 32'(resp));
		check_equal("rdata", 32'd0, data);
		read_and_check(8'h21, 0);
	endtask

	task automatic test_order_backpressure();
		write_and_check(8'h7e, bus_data_t'($random(seed)), 4'hf, 4, 5);
		read_and_check(8'h7e, 5);
	endtask

	task automatic test_contention();
		fork
			write_and_check(8'h90, bus_data_t'($random(seed)), 4'hf, 0, 0);
			read_and_check(8'h33, 0);
		join
		read_and_check(8'h90, 0);
	endtask

	task automatic test_random_traffic();
		logic [7:0] idx;
		for (int n = 0; n < 40; n++)
		begin
			idx = 8'($random(seed));
			if ($random(seed) & 1)
				write_and_check(idx, bus_data_t'($random(seed)), bus_sel_t'($random(seed)), 0, 0);
			else
				read_and_check(idx, 0);
		end
	endtask

	initial
	begin
		clk         = 1'b0;
		rst         = 1'b1;
		cycle_count = 0;
		awvalid     = 1'b0;
		awaddr      = '0;
		wvalid      = 1'b0;
		wdata       = '0;
		wstrb       = '0;
		bready      = 1'b0;
		arvalid     = 1'b0;
		araddr      = '0;
		rready      = 1'b0;
		for (int i = 0; i < MEM_DEPTH; i++)
			ref_mem[i] = fill_word(8'(i));
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		// Ready rises in the first cycle out of reset, valid, stb and cyc stay low
		@(posedge clk);
		@(negedge clk);
		check_equal("awready", 32'd1, 32'(awready));
		check_equal("wready", 32'd1, 32'(wready));
		check_equal("arready", 32'd1, 32'(arready));
		check_equal("bvalid", 32'd0, 32'(bvalid));
		check_equal("rvalid", 32'd0, 32'(rvalid));
		check_equal("wb_cyc", 32'd0, 32'(wb_cyc));
		check_equal("wb_stb", 32'd0, 32'(wb_stb));
		test_write_read();
		test_partial_strobe();
		test_error_region();
		test_order_backpressure();
		test_contention();
		test_random_traffic();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/wb_mem_model.sv */
/*
 * Wishbone slave memory for the bridge testbench.
 * Stalls one cycle in every STALL_PERIOD and acks the cycle after acceptance.
 * Addresses with bit ERR_BIT set answer err and leave the memory untouched.
 * Only the low log2(DEPTH) address bits pick a word. Fill assumes DEPTH <= 256.
 */
`default_nettype none
`include "axil_wb_defs.svh"

module wb_mem_model #(
	parameter int DEPTH        = 256,
	parameter int ERR_BIT      = 20,
	parameter int STALL_PERIOD = 3
) (
	input  wire                         i_clk,
	input  wire                         i_rst,
	input  wire                         i_cyc,
	input  wire                         i_stb,
	input  wire                         i_we,
	input  wire axil_wb_pkg::wb_addr_t  i_addr,
	input  wire axil_wb_pkg::bus_data_t i_data,
	input  wire axil_wb_pkg::bus_sel_t  i_sel,
	output logic                        o_stall,
	output logic                        o_ack,
	output logic                        o_err,
	output axil_wb_pkg::bus_data_t      o_data
);
	import axil_wb_pkg::*;

	bus_data_t                mem [0:DEPTH-1];
	int                       stall_cnt;
	logic                     accept;
	logic                     err_hit;
	logic [$clog2(DEPTH)-1:0] idx;

	// Stall on the last count of each free-running period
	assign o_stall = (stall_cnt == STALL_PERIOD - 1);
	assign accept  = i_cyc && i_stb && !o_stall;
	assign err_hit = i_addr[ERR_BIT];
	assign idx     = i_addr[$clog2(DEPTH)-1:0];

	// Fill pattern built from the whole word index
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h3c, 8'hc3};
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			stall_cnt <= 0;
			o_ack     <= 1'b0;
			o_err     <= 1'b0;
		end
		else
		begin
			stall_cnt <= o_stall ? 0 : stall_cnt + 1;
			o_ack     <= accept && !err_hit;
			o_err     <= accept && err_hit;
		end
	end

	// Byte-lane write and the old word returned with the ack
	always @(posedge i_clk)
	begin
		if (accept && !err_hit)
		begin
			if (i_we)
				for (int b = 0; b < `BUS_DATA_W / 8; b++)
					if (i_sel[b])
						mem[idx][8*b +: 8] <= i_data[8*b +: 8];
			o_data <= mem[idx];
		end
		else if (accept)
			o_data <= '0;
	end

endmodule

`default_nettype wire

/* rtl/axil_to_wb_bridge.sv */
/*
 * AXI-lite slave to pipelined Wishbone master.
 * One read and one write in flight at most. No PROT, no reset output,
 * the active-high reset is shared with the Wishbone side.
 */
`default_nettype none

module axil_to_wb_bridge (
	input  wire                          i_clk,
	input  wire                          i_rst,
	// AXI-lite write
	input  wire                          i_axi_awvalid,
	output logic                         o_axi_awready,
	input  wire axil_wb_pkg::axil_addr_t i_axi_awaddr,
	input  wire                          i_axi_wvalid,
	output logic                         o_axi_wready,
	input  wire axil_wb_pkg::bus_data_t  i_axi_wdata,
	input  wire axil_wb_pkg::bus_sel_t   i_axi_wstrb,
	output logic                         o_axi_bvalid,
	input  wire                          i_axi_bready,
	output axil_wb_pkg::axi_resp_t       o_axi_bresp,
	// AXI-lite read
	input  wire                          i_axi_arvalid,
	output logic                         o_axi_arready,
	input  wire axil_wb_pkg::axil_addr_t i_axi_araddr,
	output logic                         o_axi_rvalid,
	input  wire                          i_axi_rready,
	output axil_wb_pkg::bus_data_t       o_axi_rdata,
	output axil_wb_pkg::axi_resp_t       o_axi_rresp,
	// Wishbone master
	output logic                         o_wb_cyc,
	output logic                         o_wb_stb,
	output logic                         o_wb_we,
	output axil_wb_pkg::wb_addr_t        o_wb_addr,
	output axil_wb_pkg::bus_data_t       o_wb_data,
	output axil_wb_pkg::bus_sel_t        o_wb_sel,
	input  wire                          i_wb_stall,
	input  wire                          i_wb_ack,
	input  wire axil_wb_pkg::bus_data_t  i_wb_data,
	input  wire                          i_wb_err
);
	import axil_wb_pkg::*;

	// Write converter to arbiter
	logic      wr_cyc;
	logic      wr_stb;
	wb_addr_t  wr_addr;
	bus_data_t wr_data;
	bus_sel_t  wr_sel;
	logic      wr_stall;
	logic      wr_ack;
	logic      wr_err;
	// Read converter to arbiter
	logic      rd_cyc;
	logic      rd_stb;
	wb_addr_t  rd_addr;
	logic      rd_stall;
	logic      rd_ack;
	logic      rd_err;

	axil_wr_to_wb u_wr (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_awvalid(i_axi_awvalid), .o_awready(o_axi_awready), .i_awaddr(i_axi_awaddr),
		.i_wvalid(i_axi_wvalid), .o_wready(o_axi_wready),
		.i_wdata(i_axi_wdata), .i_wstrb(i_axi_wstrb),
		.o_bvalid(o_axi_bvalid), .i_bready(i_axi_bready), .o_bresp(o_axi_bresp),
		.o_wb_cyc(wr_cyc), .o_wb_stb(wr_stb), .o_wb_addr(wr_addr),
		.o_wb_data(wr_data), .o_wb_sel(wr_sel),
		.i_wb_stall(wr_stall), .i_wb_ack(wr_ack), .i_wb_err(wr_err)
	);

	// Read data comes straight off the bus
	axil_rd_to_wb u_rd (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_arvalid(i_axi_arvalid), .o_arready(o_axi_arready), .i_araddr(i_axi_araddr),
		.o_rvalid(o_axi_rvalid), .i_rready(i_axi_rready),
		.o_rdata(o_axi_rdata), .o_rresp(o_axi_rresp),
		.o_wb_cyc(rd_cyc), .o_wb_stb(rd_stb), .o_wb_addr(rd_addr),
		.i_wb_stall(rd_stall), .i_wb_ack(rd_ack), .i_wb_err(rd_err),
		.i_wb_data(i_wb_data)
	);

	wb_rw_arbiter u_arb (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_rd_cyc(rd_cyc), .i_rd_stb(rd_stb), .i_rd_addr(rd_addr),
		.o_rd_stall(rd_stall), .o_rd_ack(rd_ack), .o_rd_err(rd_err),
		.i_wr_cyc(wr_cyc), .i_wr_stb(wr_stb), .i_wr_addr(wr_addr),
		.i_wr_data(wr_data), .i_wr_sel(wr_sel),
		.o_wr_stall(wr_stall), .o_wr_ack(wr_ack), .o_wr_err(wr_err),
		.o_cyc(o_wb_cyc), .o_stb(o_wb_stb), .o_we(o_wb_we),
		.o_addr(o_wb_addr), .o_data(o_wb_data), .o_sel(o_wb_sel),
		.i_stall(i_wb_stall), .i_ack(i_wb_ack), .i_err(i_wb_err)
	);

endmodule

`default_nettype wire

/* rtl/wb_rw_arbiter.sv */
/*
 * Two-master Wishbone arbiter, read side and write side.
 * Grant is combinational and only moves while the owner has cyc low.
 * On a tie the master that did not use the bus last goes first.
 */
`default_nettype none

module wb_rw_arbiter (
	input  wire                         i_clk,
	input  wire                         i_rst,
	// Read master
	input  wire                         i_rd_cyc,
	input  wire                         i_rd_stb,
	input  wire axil_wb_pkg::wb_addr_t  i_rd_addr,
	output logic                        o_rd_stall,
	output logic                        o_rd_ack,
	output logic                        o_rd_err,
	// Write master
	input  wire                         i_wr_cyc,
	input  wire                         i_wr_stb,
	input  wire axil_wb_pkg::wb_addr_t  i_wr_addr,
	input  wire axil_wb_pkg::bus_data_t i_wr_data,
	input  wire axil_wb_pkg::bus_sel_t  i_wr_sel,
	output logic                        o_wr_stall,
	output logic                        o_wr_ack,
	output logic                        o_wr_err,
	// Shared bus
	output logic                        o_cyc,
	output logic                        o_stb,
	output logic                        o_we,
	output axil_wb_pkg::wb_addr_t       o_addr,
	output axil_wb_pkg::bus_data_t      o_data,
	output axil_wb_pkg::bus_sel_t       o_sel,
	input  wire                         i_stall,
	input  wire                         i_ack,
	input  wire                         i_err
);
	import axil_wb_pkg::*;

	arb_owner_t owner;
	arb_owner_t last_owner;
	arb_owner_t grant;
	logic       bus_busy;

	// Owner still in a cycle, grant is locked
	assign bus_busy = (owner == OWNER_WR) ? i_wr_cyc : i_rd_cyc;

	always_comb
	begin
		grant = owner;
		if (!bus_busy)
		begin
			if (i_rd_cyc && i_wr_cyc)
				grant = (last_owner == OWNER_RD) ? OWNER_WR : OWNER_RD;
			else if (i_wr_cyc)
				grant = OWNER_WR;
			else if (i_rd_cyc)
				grant = OWNER_RD;
		end
	end

	// last_owner tracks who last got a request accepted
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			owner      <= OWNER_RD;
			last_owner <= OWNER_WR;
		end
		else
		begin
			owner <= grant;
			if (o_stb && !i_stall)
				last_owner <= grant;
		end
	end

	////////////////////////////////////////
	// Request mux
	////////////////////////////////////////

	assign o_cyc  = (grant == OWNER_WR) ? i_wr_cyc : i_rd_cyc;
	assign o_stb  = (grant == OWNER_WR) ? i_wr_stb : i_rd_stb;
	assign o_we   = (grant == OWNER_WR);
	assign o_addr = (grant == OWNER_WR) ? i_wr_addr : i_rd_addr;
	assign o_data = i_wr_data;
	// Reads take the full word
	assign o_sel  = (grant == OWNER_WR) ? i_wr_sel : '1;

	// Returns go to the owner only, the other one sees stall
	assign o_rd_stall = (grant == OWNER_RD) ? i_stall : 1'b1;
	assign o_rd_ack   = (grant == OWNER_RD) && i_ack;
	assign o_rd_err   = (grant == OWNER_RD) && i_err;
	assign o_wr_stall = (grant == OWNER_WR) ? i_stall : 1'b1;
	assign o_wr_ack   = (grant == OWNER_WR) && i_ack;
	assign o_wr_err   = (grant == OWNER_WR) && i_err;

endmodule

`default_nettype wire

/* rtl/axil_rd_to_wb.sv */
/*
 * AXI-lite AR request to one Wishbone read, R response back.
 * One read in flight. Byte lanes are all selected by the arbiter.
 * On err the returned data is zero with SLVERR.
 */
`default_nettype none
`include "axil_wb_defs.svh"

module axil_rd_to_wb (
	input  wire                          i_clk,
	input  wire                          i_rst,
	// AR channel
	input  wire                          i_arvalid,
	output logic                         o_arready,
	input  wire axil_wb_pkg::axil_addr_t i_araddr,
	// R channel
	output logic                         o_rvalid,
	input  wire                          i_rready,
	output axil_wb_pkg::bus_data_t       o_rdata,
	output axil_wb_pkg::axi_resp_t       o_rresp,
	// Wishbone master
	output logic                         o_wb_cyc,
	output logic                         o_wb_stb,
	output axil_wb_pkg::wb_addr_t        o_wb_addr,
	input  wire                          i_wb_stall,
	input  wire                          i_wb_ack,
	input  wire                          i_wb_err,
	input  wire axil_wb_pkg::bus_data_t  i_wb_data
);
	import axil_wb_pkg::*;

	rd_state_t state;
	wb_addr_t  rd_addr;
	logic      ar_xfer;
	logic      r_xfer;

	assign ar_xfer = i_arvalid && o_arready;
	assign r_xfer  = o_rvalid && i_rready;

	// Low after the AR transfer, high again once R is taken
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_arready <= 1'b0;
		else if (ar_xfer)
			o_arready <= 1'b0;
		else if (state == RD_IDLE || r_xfer)
			o_arready <= 1'b1;
	end

	always_ff @(posedge i_clk)
		if (ar_xfer)
			rd_addr <= i_araddr[`AXIL_ADDR_W-1:`AXIL_LSB];

	////////////////////////////////////////
	// Bus FSM
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			state <= RD_IDLE;
		else
		begin
			case (state)
			RD_IDLE:
				if (ar_xfer)
					state <= RD_BUS_REQ;
			// Ack in the accept cycle is taken as well
			RD_BUS_REQ:
				if (i_wb_ack || i_wb_err)
					state <= RD_RESPOND;
				else if (!i_wb_stall)
					state <= RD_BUS_WAIT;
			RD_BUS_WAIT:
				if (i_wb_ack || i_wb_err)
					state <= RD_RESPOND;
			RD_RESPOND:
				if (i_rready)
					state <= RD_IDLE;
			default:
				state <= RD_IDLE;
			endcase
		end
	end

	// Data and response latched together, zero data on error
	always_ff @(posedge i_clk)
		if (o_wb_cyc && (i_wb_ack || i_wb_err))
		begin
			o_rdata <= i_wb_err ? '0 : i_wb_data;
			o_rresp <= i_wb_err ? `RESP_SLVERR : `RESP_OKAY;
		end

	assign o_rvalid  = (state == RD_RESPOND);
	assign o_wb_cyc  = (state == RD_BUS_REQ) || (state == RD_BUS_WAIT);
	assign o_wb_stb  = (state == RD_BUS_REQ);
	assign o_wb_addr = rd_addr;

endmodule

`default_nettype wire

/* rtl/axil_wr_to_wb.sv */
/*
 * AXI-lite AW and W channels to one Wishbone write, B response back.
 * One write in flight. AW and W may arrive in either order or together.
 * No new AW or W is taken while B waits for bready.
 */
`default_nettype none
`include "axil_wb_defs.svh"

module axil_wr_to_wb (
	input  wire                         i_clk,
	input  wire                         i_rst,
	// AW channel
	input  wire                         i_awvalid,
	output logic                        o_awready,
	input  wire axil_wb_pkg::axil_addr_t i_awaddr,
	// W channel
	input  wire                         i_wvalid,
	output logic                        o_wready,
	input  wire axil_wb_pkg::bus_data_t i_wdata,
	input  wire axil_wb_pkg::bus_sel_t  i_wstrb,
	// B channel
	output logic                        o_bvalid,
	input  wire                         i_bready,
	output axil_wb_pkg::axi_resp_t      o_bresp,
	// Wishbone master
	output logic                        o_wb_cyc,
	output logic                        o_wb_stb,
	output axil_wb_pkg::wb_addr_t       o_wb_addr,
	output axil_wb_pkg::bus_data_t      o_wb_data,
	output axil_wb_pkg::bus_sel_t       o_wb_sel,
	input  wire                         i_wb_stall,
	input  wire                         i_wb_ack,
	input  wire                         i_wb_err
);
	import axil_wb_pkg::*;

	wr_state_t state;
	// Holding registers and their full flags
	logic      aw_full;
	logic      w_full;
	wb_addr_t  aw_addr;
	bus_data_t w_data;
	bus_sel_t  w_strb;
	// Handshakes this cycle
	logic      aw_xfer;
	logic      w_xfer;
	logic      b_xfer;
	logic      bus_done;

	assign aw_xfer  = i_awvalid && o_awready;
	assign w_xfer   = i_wvalid && o_wready;
	assign b_xfer   = o_bvalid && i_bready;
	assign bus_done = o_wb_cyc && (i_wb_ack || i_wb_err);

	////////////////////////////////////////
	// AW and W capture
	////////////////////////////////////////

	// Ready drops on its own transfer, comes back once B is taken
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			o_awready <= 1'b0;
			o_wready  <= 1'b0;
			aw_full   <= 1'b0;
			w_full    <= 1'b0;
		end
		else if (b_xfer)
		begin
			o_awready <= 1'b1;
			o_wready  <= 1'b1;
			aw_full   <= 1'b0;
			w_full    <= 1'b0;
		end
		else
		begin
			if (aw_xfer)
				o_awready <= 1'b0;
			else if (state == WR_COLLECT && !aw_full)
				o_awready <= 1'b1;
			if (w_xfer)
				o_wready <= 1'b0;
			else if (state == WR_COLLECT && !w_full)
				o_wready <= 1'b1;
			if (aw_xfer)
				aw_full <= 1'b1;
			if (w_xfer)
				w_full <= 1'b1;
		end
	end

	// Payload only, word address drops the byte offset
	always_ff @(posedge i_clk)
	begin
		if (aw_xfer)
			aw_addr <= i_awaddr[`AXIL_ADDR_W-1:`AXIL_LSB];
		if (w_xfer)
		begin
			w_data <= i_wdata;
			w_strb <= i_wstrb;
		end
	end

	////////////////////////////////////////
	// Bus FSM
	////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			state <= WR_COLLECT;
		else
		begin
			case (state)
			// Go as soon as the second half lands
			WR_COLLECT:
				if ((aw_full || aw_xfer) && (w_full || w_xfer))
					state <= WR_BUS_REQ;
			WR_BUS_REQ:
				if (i_wb_ack || i_wb_err)
					state <= WR_RESPOND;
				else if (!i_wb_stall)
					state <= WR_BUS_WAIT;
			WR_BUS_WAIT:
				if (i_wb_ack || i_wb_err)
					state <= WR_RESPOND;
			WR_RESPOND:
				if (i_bready)
					state <= WR_COLLECT;
			default:
				state <= WR_COLLECT;
			endcase
		end
	end

	// Response held until bready
	always_ff @(posedge i_clk)
		if (bus_done)
			o_bresp <= i_wb_err ? `RESP_SLVERR : `RESP_OKAY;

	assign o_bvalid  = (state == WR_RESPOND);
	// cyc stays up through the wait for ack
	assign o_wb_cyc  = (state == WR_BUS_REQ) || (state == WR_BUS_WAIT);
	assign o_wb_stb  = (state == WR_BUS_REQ);
	assign o_wb_addr = aw_addr;
	assign o_wb_data = w_data;
	assign o_wb_sel  = w_strb;

endmodule

`default_nettype wire

/* rtl/axil_wb_pkg.sv */
/*
 * Types shared by the bridge RTL.
 * Widths come from axil_wb_defs.svh, so that header sets the bus size.
 */
`default_nettype none
`include "axil_wb_defs.svh"

package axil_wb_pkg;

	// Bus vectors
	typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
	typedef logic [`AXIL_ADDR_W-`AXIL_LSB-1:0] wb_addr_t;
	typedef logic [`BUS_DATA_W-1:0] bus_data_t;
	// Byte lanes, also used for WSTRB
	typedef logic [`BUS_DATA_W/8-1:0] bus_sel_t;
	typedef logic [1:0] axi_resp_t;

	// Write converter FSM
	typedef enum logic [1:0] {WR_COLLECT, WR_BUS_REQ, WR_BUS_WAIT, WR_RESPOND} wr_state_t;

	// Read converter FSM
	typedef enum logic [1:0] {RD_IDLE, RD_BUS_REQ, RD_BUS_WAIT, RD_RESPOND} rd_state_t;

	// Which master holds the shared bus
	typedef enum logic {OWNER_RD, OWNER_WR} arb_owner_t;

endpackage

`default_nettype wire

/* include/axil_wb_defs.svh */
/*
 * Bus widths and AXI response codes for the AXI-lite to Wishbone bridge.
 * The Wishbone address is a word address, so it is AXIL_ADDR_W - AXIL_LSB wide.
 * AXIL_LSB must equal log2(BUS_DATA_W/8).
 */
`ifndef AXIL_WB_DEFS_SVH
`define AXIL_WB_DEFS_SVH

////////////////////////////////////////
// Bus widths
////////////////////////////////////////

// AXI byte address
`define AXIL_ADDR_W 28
// Data on both AXI and Wishbone
`define BUS_DATA_W 32
// Byte offset bits below the word address
`define AXIL_LSB 2

////////////////////////////////////////
// AXI response codes
////////////////////////////////////////

// Wishbone ack
`define RESP_OKAY 2'b00
// Wishbone err
`define RESP_SLVERR 2'b10

`endif
